// ==== Bender.yml ====
package:
  name: csr_core

sources:
  - logic/csr_addr_pkg.sv
  - logic/csr_fields_pkg.sv
  - logic/csr_write_decode.sv
  - logic/csr_mode_regs.sv
  - logic/csr_timer.sv
  - logic/csr_read_irq.sv
  - logic/csr_top.sv
  - target: test
    files:
      - verification/csr_tb.sv

// ==== files.f ====
logic/csr_addr_pkg.sv
logic/csr_fields_pkg.sv
logic/csr_write_decode.sv
logic/csr_mode_regs.sv
logic/csr_timer.sv
logic/csr_read_irq.sv
logic/csr_top.sv
verification/csr_tb.sv

// ==== logic/csr_addr_pkg.sv ====
`default_nettype none

package csr_addr_pkg;

    localparam int CSR_ADDR_W = 14;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // exception and mode registers
    localparam csr_addr_t CRMD   = 14'h000;
    localparam csr_addr_t PRMD   = 14'h001;
    localparam csr_addr_t ECTL   = 14'h004;
    localparam csr_addr_t ESTAT  = 14'h005;
    localparam csr_addr_t ERA    = 14'h006;
    localparam csr_addr_t EENTRY = 14'h00c;

    // scratch
    localparam csr_addr_t SAVE0  = 14'h030;
    localparam csr_addr_t SAVE1  = 14'h031;
    localparam csr_addr_t SAVE2  = 14'h032;
    localparam csr_addr_t SAVE3  = 14'h033;

    // timer
    localparam csr_addr_t TCFG   = 14'h041;
    localparam csr_addr_t TVAL   = 14'h042;
    localparam csr_addr_t TICLR  = 14'h044;

endpackage

`default_nettype wire

// ==== logic/csr_fields_pkg.sv ====
`default_nettype none

package csr_fields_pkg;

    localparam int CSR_W = 32;

    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } csr_crmd_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } csr_prmd_t;

    typedef struct packed {
        logic        rsvd31;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [3:0]  rsvd15;
        logic        ti;
        logic        rsvd10;
        logic [7:0]  hwi;
        logic [1:0]  swi;
    } csr_estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } csr_tcfg_t;

    // one write word viewed per target register
    typedef union packed {
        logic [CSR_W-1:0] raw;
        csr_crmd_t        crmd;
        csr_prmd_t        prmd;
        csr_estat_t       estat;
        csr_tcfg_t        tcfg;
    } csr_word_u;

    // local interrupt enables with no source at bit 10
    localparam logic [CSR_W-1:0] ECTL_LIE_MASK = 32'h0000_1bff;
    localparam logic [CSR_W-1:0] TICLR_CLR     = 32'h0000_0001;

endpackage

`default_nettype wire

// ==== logic/csr_mode_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_mode_regs
    import csr_fields_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      crmd_wen,
    input  logic                      prmd_wen,
    input  logic                      ectl_wen,
    input  logic                      estat_wen,
    input  logic                      era_wen,
    input  logic                      eentry_wen,
    input  logic [3:0]                save_wen,
    input  csr_word_u                 wr_data,
    input  logic                      excp_flush,
    input  logic                      ertn_flush,
    input  logic [CSR_W-1:0]          era_in,
    input  logic [5:0]                ecode_in,
    input  logic [8:0]                esubcode_in,
    input  logic [7:0]                interrupt,
    output csr_crmd_t                 crmd,
    output csr_prmd_t                 prmd,
    output logic [CSR_W-1:0]          ectl,
    output csr_estat_t                estat_base,
    output logic [CSR_W-1:0]          era,
    output logic [CSR_W-1:0]          eentry,
    output logic [3:0][CSR_W-1:0]     save
);

    // direct address mode out of reset
    localparam csr_crmd_t CRMD_RESET = 32'h0000_0008;

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= CRMD_RESET;
        end else if (excp_flush) begin
            crmd.plv <= 2'b00;
            crmd.ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (crmd_wen) begin
            crmd.plv  <= wr_data.crmd.plv;
            crmd.ie   <= wr_data.crmd.ie;
            crmd.da   <= wr_data.crmd.da;
            crmd.pg   <= wr_data.crmd.pg;
            crmd.datf <= wr_data.crmd.datf;
            crmd.datm <= wr_data.crmd.datm;
        end
    end

    // previous mode saved on entry
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd.pplv <= crmd.plv;
            prmd.pie  <= crmd.ie;
        end else if (prmd_wen) begin
            prmd.pplv <= wr_data.prmd.pplv;
            prmd.pie  <= wr_data.prmd.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl <= '0;
        end else if (ectl_wen) begin
            ectl <= wr_data.raw & ECTL_LIE_MASK;
        end
    end

    // timer bit is merged on the read side
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_base <= '0;
        end else begin
            estat_base.hwi <= interrupt;
            if (excp_flush) begin
                estat_base.ecode    <= ecode_in;
                estat_base.esubcode <= esubcode_in;
            end else if (estat_wen) begin
                estat_base.swi <= wr_data.estat.swi;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush) begin
            era <= era_in;
        end else if (era_wen) begin
            era <= wr_data.raw;
        end
    end

    // entry point is 64-byte aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            eentry[5:0] <= 6'b0;
        end else if (eentry_wen) begin
            eentry[CSR_W-1:6] <= wr_data.raw[CSR_W-1:6];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (save_wen[i]) begin
                save[i] <= wr_data.raw;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/csr_read_irq.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_read_irq
    import csr_addr_pkg::*;
    import csr_fields_pkg::*;
#(
    parameter int TIMER_WIDTH = 32
)
(
    input  csr_addr_t                 rd_addr,
    input  csr_crmd_t                 crmd,
    input  csr_prmd_t                 prmd,
    input  logic [CSR_W-1:0]          ectl,
    input  csr_estat_t                estat_base,
    input  logic [CSR_W-1:0]          era,
    input  logic [CSR_W-1:0]          eentry,
    input  logic [3:0][CSR_W-1:0]     save,
    input  csr_tcfg_t                 tcfg,
    input  logic [TIMER_WIDTH-1:0]    tval,
    input  logic                      timer_irq,
    output logic [CSR_W-1:0]          rd_data,
    output logic                      has_int,
    output logic [1:0]                plv
);

    csr_estat_t       estat;
    logic [CSR_W-1:0] estat_word;

    always_comb begin
        estat    = estat_base;
        estat.ti = timer_irq;
    end

    assign estat_word = estat;

    always_comb begin
        case (rd_addr)
            CRMD:    rd_data = crmd;
            PRMD:    rd_data = prmd;
            ECTL:    rd_data = ectl;
            ESTAT:   rd_data = estat_word;
            ERA:     rd_data = era;
            EENTRY:  rd_data = eentry;
            SAVE0:   rd_data = save[0];
            SAVE1:   rd_data = save[1];
            SAVE2:   rd_data = save[2];
            SAVE3:   rd_data = save[3];
            TCFG:    rd_data = tcfg;
            TVAL:    rd_data = CSR_W'(tval);
            // TICLR and unmapped numbers read zero
            default: rd_data = '0;
        endcase
    end

    // pending and enabled over bits 12:0
    assign has_int = crmd.ie && ((ectl[12:0] & estat_word[12:0]) != 13'b0);
    assign plv     = crmd.plv;

endmodule

`default_nettype wire

// ==== logic/csr_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_timer
    import csr_fields_pkg::*;
#(
    parameter int TIMER_WIDTH = 32
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tcfg_wen,
    input  logic                   ticlr_wen,
    input  csr_word_u              wr_data,
    output csr_tcfg_t              tcfg,
    output logic [TIMER_WIDTH-1:0] tval,
    output logic                   timer_irq
);

    logic                   timer_en;
    logic [TIMER_WIDTH-1:0] load_new;
    logic [TIMER_WIDTH-1:0] load_cfg;
    logic                   fire;
    logic                   clear;

    // count is INITVAL in units of four ticks
    assign load_new = TIMER_WIDTH'({wr_data.tcfg.initval, 2'b00});
    assign load_cfg = TIMER_WIDTH'({tcfg.initval, 2'b00});

    // a new config on the same edge takes over
    assign fire  = timer_en && (tval == '0) && !tcfg_wen;
    assign clear = ticlr_wen && ((wr_data.raw & TICLR_CLR) != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg     <= '0;
            tval     <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_wen) begin
            tcfg     <= wr_data.tcfg;
            tval     <= load_new;
            timer_en <= wr_data.tcfg.en;
        end else if (fire) begin
            if (tcfg.periodic) begin
                tval <= load_cfg;
            end else begin
                tval     <= '1;
                timer_en <= 1'b0;
            end
        end else if (timer_en) begin
            tval <= tval - 1'b1;
        end
    end

    // clear beats a new expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_irq <= 1'b0;
        end else if (clear) begin
            timer_irq <= 1'b0;
        end else if (fire) begin
            timer_irq <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/csr_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_top
    import csr_addr_pkg::*;
    import csr_fields_pkg::*;
#(
    parameter int TIMER_WIDTH = 32
)
(
    input  logic             clk,
    input  logic             reset,
    input  csr_addr_t        rd_addr,
    output logic [CSR_W-1:0] rd_data,
    input  logic             csr_wr_en,
    input  csr_addr_t        wr_addr,
    input  logic [CSR_W-1:0] wr_data,
    input  logic [7:0]       interrupt,
    output logic             has_int,
    input  logic             excp_flush,
    input  logic             ertn_flush,
    input  logic [CSR_W-1:0] era_in,
    input  logic [5:0]       ecode_in,
    input  logic [8:0]       esubcode_in,
    output logic [1:0]       plv,
    output logic [CSR_W-1:0] eentry_out,
    output logic [CSR_W-1:0] era_out
);

    logic                   crmd_wen;
    logic                   prmd_wen;
    logic                   ectl_wen;
    logic                   estat_wen;
    logic                   era_wen;
    logic                   eentry_wen;
    logic                   tcfg_wen;
    logic                   ticlr_wen;
    logic [3:0]             save_wen;
    csr_crmd_t              crmd;
    csr_prmd_t              prmd;
    logic [CSR_W-1:0]       ectl;
    csr_estat_t             estat_base;
    logic [3:0][CSR_W-1:0]  save;
    csr_tcfg_t              tcfg;
    logic [TIMER_WIDTH-1:0] tval;
    logic                   timer_irq;

    csr_write_decode u_write_decode (
        .csr_wr_en  (csr_wr_en),
        .wr_addr    (wr_addr),
        .crmd_wen   (crmd_wen),
        .prmd_wen   (prmd_wen),
        .ectl_wen   (ectl_wen),
        .estat_wen  (estat_wen),
        .era_wen    (era_wen),
        .eentry_wen (eentry_wen),
        .tcfg_wen   (tcfg_wen),
        .save_wen   (save_wen),
        .ticlr_wen  (ticlr_wen)
    );

    csr_mode_regs u_mode_regs (
        .clk         (clk),
        .reset       (reset),
        .crmd_wen    (crmd_wen),
        .prmd_wen    (prmd_wen),
        .ectl_wen    (ectl_wen),
        .estat_wen   (estat_wen),
        .era_wen     (era_wen),
        .eentry_wen  (eentry_wen),
        .save_wen    (save_wen),
        .wr_data     (wr_data),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .interrupt   (interrupt),
        .crmd        (crmd),
        .prmd        (prmd),
        .ectl        (ectl),
        .estat_base  (estat_base),
        .era         (era_out),
        .eentry      (eentry_out),
        .save        (save)
    );

    csr_timer #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) u_timer (
        .clk       (clk),
        .reset     (reset),
        .tcfg_wen  (tcfg_wen),
        .ticlr_wen (ticlr_wen),
        .wr_data   (wr_data),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_irq (timer_irq)
    );

    csr_read_irq #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) u_read_irq (
        .rd_addr    (rd_addr),
        .crmd       (crmd),
        .prmd       (prmd),
        .ectl       (ectl),
        .estat_base (estat_base),
        .era        (era_out),
        .eentry     (eentry_out),
        .save       (save),
        .tcfg       (tcfg),
        .tval       (tval),
        .timer_irq  (timer_irq),
        .rd_data    (rd_data),
        .has_int    (has_int),
        .plv        (plv)
    );

endmodule

`default_nettype wire

// ==== logic/csr_write_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_write_decode
    import csr_addr_pkg::*;
(
    input  logic       csr_wr_en,
    input  csr_addr_t  wr_addr,
    output logic       crmd_wen,
    output logic       prmd_wen,
    output logic       ectl_wen,
    output logic       estat_wen,
    output logic       era_wen,
    output logic       eentry_wen,
    output logic       tcfg_wen,
    output logic [3:0] save_wen,
    output logic       ticlr_wen
);

    assign crmd_wen   = csr_wr_en && (wr_addr == CRMD);
    assign prmd_wen   = csr_wr_en && (wr_addr == PRMD);
    assign ectl_wen   = csr_wr_en && (wr_addr == ECTL);
    assign estat_wen  = csr_wr_en && (wr_addr == ESTAT);
    assign era_wen    = csr_wr_en && (wr_addr == ERA);
    assign eentry_wen = csr_wr_en && (wr_addr == EENTRY);
    assign tcfg_wen   = csr_wr_en && (wr_addr == TCFG);
    assign ticlr_wen  = csr_wr_en && (wr_addr == TICLR);

    // TVAL is read only and has no enable
    assign save_wen[0] = csr_wr_en && (wr_addr == SAVE0);
    assign save_wen[1] = csr_wr_en && (wr_addr == SAVE1);
    assign save_wen[2] = csr_wr_en && (wr_addr == SAVE2);
    assign save_wen[3] = csr_wr_en && (wr_addr == SAVE3);

endmodule

`default_nettype wire

// ==== verification/csr_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_tb
    import csr_addr_pkg::*;
();

    localparam int CLK_PERIOD       = 8;
    localparam int TIMER_WIDTH      = 32;
    localparam int N_RW             = 200;
    localparam int N_EXC            = 20;
    localparam int N_TIMER_RUNS     = 4;
    localparam int TIMER_RUN_CYCLES = 120;
    localparam int N_IRQ            = 300;
    localparam int TEST_CYCLES      = 20 + 3 * N_RW + 12 * N_EXC
                                    + N_TIMER_RUNS * TIMER_RUN_CYCLES + N_IRQ;

    logic        clk;
    logic        reset;
    csr_addr_t   rd_addr;
    logic [31:0] rd_data;
    logic        csr_wr_en;
    csr_addr_t   wr_addr;
    logic [31:0] wr_data;
    logic [7:0]  interrupt;
    logic        has_int;
    logic        excp_flush;
    logic        ertn_flush;
    logic [31:0] era_in;
    logic [5:0]  ecode_in;
    logic [8:0]  esubcode_in;
    logic [1:0]  plv;
    logic [31:0] eentry_out;
    logic [31:0] era_out;

    // register model
    logic [31:0]            m_crmd;
    logic [31:0]            m_prmd;
    logic [31:0]            m_ectl;
    logic [1:0]             m_swi;
    logic [7:0]             m_hwi;
    logic [5:0]             m_ecode;
    logic [8:0]             m_esub;
    logic [31:0]            m_era;
    logic [31:0]            m_eentry;
    logic [31:0]            m_save [4];
    logic [31:0]            m_tcfg;
    logic [TIMER_WIDTH-1:0] m_tval;
    logic                   m_ten;
    logic                   m_tirq;

    logic [31:0] rng_state = 32'd72971;
    logic [31:0] last_rd;
    int          n_checks;
    int          n_errors;
    int          test_errors;

    csr_addr_t rw_regs [10] = '{CRMD, PRMD, ECTL, ESTAT, ERA, EENTRY,
                                SAVE0, SAVE1, SAVE2, SAVE3};

    csr_top #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .csr_wr_en   (csr_wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .interrupt   (interrupt),
        .has_int     (has_int),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .plv         (plv),
        .eentry_out  (eentry_out),
        .era_out     (era_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            test_errors++;
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic model_reset();
        m_crmd   = 32'h0000_0008;
        m_prmd   = '0;
        m_ectl   = '0;
        m_swi    = '0;
        m_hwi    = '0;
        m_ecode  = '0;
        m_esub   = '0;
        m_era    = 'x;
        m_eentry = {26'bx, 6'b0};
        for (int i = 0; i < 4; i++) begin
            m_save[i] = 'x;
        end
        m_tcfg = '0;
        m_tval = '0;
        m_ten  = 1'b0;
        m_tirq = 1'b0;
    endtask

    function automatic logic writes(input csr_addr_t a);
        return csr_wr_en && (wr_addr == a);
    endfunction

    function automatic logic [31:0] model_estat();
        return {1'b0, m_esub, m_ecode, 4'b0, m_tirq, 1'b0, m_hwi, m_swi};
    endfunction

    function automatic logic model_has_int();
        logic [31:0] est;
        est = model_estat();
        return m_crmd[2] && ((m_ectl[12:0] & est[12:0]) != 13'b0);
    endfunction

    function automatic logic [31:0] model_read(input csr_addr_t a);
        case (a)
            CRMD:    return m_crmd;
            PRMD:    return m_prmd;
            ECTL:    return m_ectl;
            ESTAT:   return model_estat();
            ERA:     return m_era;
            EENTRY:  return m_eentry;
            SAVE0:   return m_save[0];
            SAVE1:   return m_save[1];
            SAVE2:   return m_save[2];
            SAVE3:   return m_save[3];
            TCFG:    return m_tcfg;
            TVAL:    return 32'(m_tval);
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic is_mapped(input csr_addr_t a);
        return a inside {CRMD, PRMD, ECTL, ESTAT, ERA, EENTRY, SAVE0, SAVE1, SAVE2, SAVE3,
                         TCFG, TVAL, TICLR};
    endfunction

    // state update for one rising edge from the inputs held now
    task automatic model_edge();
        logic [31:0] crmd_n;
        logic [31:0] prmd_n;
        logic        tcfg_we;
        logic        clr;
        logic        fire;
        crmd_n = m_crmd;
        prmd_n = m_prmd;
        if (excp_flush) begin
            prmd_n      = {29'b0, m_crmd[2:0]};
            crmd_n[2:0] = 3'b000;
            m_ecode     = ecode_in;
            m_esub      = esubcode_in;
            m_era       = era_in;
        end else begin
            if (ertn_flush) begin
                crmd_n[2:0] = m_prmd[2:0];
            end else if (writes(CRMD)) begin
                crmd_n = wr_data & 32'h0000_01ff;
            end
            if (writes(PRMD)) begin
                prmd_n = wr_data & 32'h0000_0007;
            end
            if (writes(ESTAT)) begin
                m_swi = wr_data[1:0];
            end
            if (writes(ERA)) begin
                m_era = wr_data;
            end
        end
        m_crmd = crmd_n;
        m_prmd = prmd_n;
        if (writes(ECTL)) begin
            m_ectl = wr_data & 32'h0000_1bff;
        end
        if (writes(EENTRY)) begin
            m_eentry = {wr_data[31:6], 6'b0};
        end
        for (int i = 0; i < 4; i++) begin
            if (writes(SAVE0 + 14'(i))) begin
                m_save[i] = wr_data;
            end
        end
        m_hwi = interrupt;

        // timer expiry only while running and not reconfigured
        tcfg_we = writes(TCFG);
        clr     = writes(TICLR) && wr_data[0];
        fire    = m_ten && (m_tval == '0) && !tcfg_we;
        if (clr) begin
            m_tirq = 1'b0;
        end else if (fire) begin
            m_tirq = 1'b1;
        end
        if (tcfg_we) begin
            m_tcfg = wr_data;
            m_tval = TIMER_WIDTH'({wr_data[31:2], 2'b00});
            m_ten  = wr_data[0];
        end else if (fire) begin
            if (m_tcfg[1]) begin
                m_tval = TIMER_WIDTH'({m_tcfg[31:2], 2'b00});
            end else begin
                m_tval = '1;
                m_ten  = 1'b0;
            end
        end else if (m_ten) begin
            m_tval = m_tval - 1'b1;
        end
    endtask

    // check outputs, then advance DUT and model by one edge
    task automatic step_cycle();
        logic [31:0] exp_rd;
        #1;
        exp_rd  = model_read(rd_addr);
        last_rd = rd_data;
        if (!$isunknown(exp_rd)) begin
            compare(rd_data, exp_rd, $sformatf("rd_data at %h", rd_addr));
        end
        compare(has_int, model_has_int(), "has_int");
        compare(plv, m_crmd[1:0], "plv");
        if (!$isunknown(m_era)) begin
            compare(era_out, m_era, "era_out");
        end
        if (!$isunknown(m_eentry)) begin
            compare(eentry_out, m_eentry, "eentry_out");
        end
        model_edge();
        @(posedge clk);
        #1;
        csr_wr_en  = 1'b0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic drive_write(input csr_addr_t a, input logic [31:0] d);
        csr_wr_en = 1'b1;
        wr_addr   = a;
        wr_data   = d;
    endtask

    task automatic read_check(input csr_addr_t a, input logic [31:0] exp, input string what);
        rd_addr = a;
        #1;
        compare(rd_data, exp, what);
        step_cycle();
    endtask

    task automatic end_test(input string name);
        $display("test %-8s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    // n is the number of edges after the reference edge at which the bit shows
    task automatic edges_to_timer_bit(output int n);
        n = -1;
        do begin
            n++;
            rd_addr = ESTAT;
            step_cycle();
        end while (!last_rd[11] && n < 64);
    endtask

    task automatic timer_run(input logic periodic);
        int          k;
        int          n;
        logic [31:0] cfg;
        k   = 1 + int'(next_rand() % 6);
        cfg = {30'(k), periodic, 1'b1};
        drive_write(TICLR, 32'h1);
        step_cycle();
        drive_write(TCFG, cfg);
        step_cycle();
        edges_to_timer_bit(n);
        compare(n, 4 * k + 1, "edges to first expiry");
        drive_write(TICLR, 32'h1);
        step_cycle();
        rd_addr = ESTAT;
        #1;
        compare(rd_data[11], 1'b0, "timer bit after clear");
        step_cycle();
        if (periodic) begin
            // expiry edge lies three edges before the new reference
            edges_to_timer_bit(n);
            compare(n + 3, 4 * k + 1, "edges to periodic expiry");
        end else begin
            for (int j = 0; j < 4 * k + 6; j++) begin
                rd_addr = (j % 2 == 0) ? TVAL : ESTAT;
                step_cycle();
            end
            rd_addr = ESTAT;
            #1;
            compare(rd_data[11], 1'b0, "one-shot timer bit stays clear");
            step_cycle();
        end
        read_check(TCFG, cfg, "tcfg read back");
        drive_write(TCFG, 32'h0);
        step_cycle();
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] era_v;
        csr_addr_t   a;
        logic [1:0]  old_plv;
        logic        old_ie;
        n_checks    = 0;
        n_errors    = 0;
        test_errors = 0;
        reset       = 1'b1;
        rd_addr     = CRMD;
        csr_wr_en   = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        interrupt   = '0;
        excp_flush  = 1'b0;
        ertn_flush  = 1'b0;
        era_in      = '0;
        ecode_in    = '0;
        esubcode_in = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        read_check(CRMD, 32'h8, "crmd after reset");
        read_check(PRMD, 32'h0, "prmd after reset");
        read_check(ECTL, 32'h0, "ectl after reset");
        read_check(ESTAT, 32'h0, "estat after reset");
        read_check(TCFG, 32'h0, "tcfg after reset");
        read_check(TVAL, 32'h0, "tval after reset");
        compare(has_int, 1'b0, "has_int after reset");
        compare(plv, 2'b00, "plv after reset");
        end_test("reset");

        for (int i = 0; i < N_RW; i++) begin
            r = next_rand();
            a = rw_regs[r % 10];
            drive_write(a, next_rand());
            rd_addr = rw_regs[(r >> 8) % 10];
            step_cycle();
            rd_addr = a;
            step_cycle();
            if (i % 4 == 0) begin
                do begin
                    r = next_rand();
                    a = r[13:0];
                end while (is_mapped(a));
                read_check(a, 32'h0, "unmapped read");
            end
        end
        end_test("rw");

        for (int i = 0; i < N_EXC; i++) begin
            r       = next_rand();
            old_plv = r[1:0];
            old_ie  = r[2];
            drive_write(CRMD, r & 32'h0000_01ff);
            step_cycle();
            r           = next_rand();
            era_v       = next_rand();
            excp_flush  = 1'b1;
            era_in      = era_v;
            ecode_in    = r[5:0];
            esubcode_in = r[14:6];
            step_cycle();
            compare(plv, 2'b00, "plv after entry");
            compare(era_out, era_v, "era_out after entry");
            read_check(PRMD, {29'b0, old_ie, old_plv}, "prmd after entry");
            rd_addr = ESTAT;
            #1;
            compare(rd_data[21:16], r[5:0], "ecode after entry");
            compare(rd_data[30:22], r[14:6], "esubcode after entry");
            step_cycle();
            rd_addr = CRMD;
            #1;
            compare(rd_data[2], 1'b0, "ie after entry");
            step_cycle();
            ertn_flush = 1'b1;
            step_cycle();
            compare(plv, old_plv, "plv after return");
            rd_addr = CRMD;
            #1;
            compare(rd_data[2], old_ie, "ie after return");
            step_cycle();
            // entry and a CRMD write on the same edge
            drive_write(CRMD, next_rand() | 32'h7);
            excp_flush = 1'b1;
            era_in     = next_rand();
            step_cycle();
            compare(plv, 2'b00, "plv with entry over write");
            rd_addr = CRMD;
            #1;
            compare(rd_data[2], 1'b0, "ie with entry over write");
            step_cycle();
            ertn_flush = 1'b1;
            step_cycle();
        end
        end_test("except");

        timer_run(1'b0);
        timer_run(1'b1);
        timer_run(1'b0);
        timer_run(1'b1);
        end_test("timer");

        for (int i = 0; i < N_IRQ; i++) begin
            r         = next_rand();
            interrupt = r[7:0];
            rd_addr   = ESTAT;
            case (r[11:8] % 8)
                0: drive_write(ECTL, next_rand());
                1: drive_write(ESTAT, next_rand());
                2: drive_write(CRMD, next_rand());
                3: drive_write(TCFG, {28'b0, r[13:12], r[14], 1'b1});
                4: drive_write(TICLR, 32'h1);
                default: ;
            endcase
            step_cycle();
        end
        interrupt = '0;
        step_cycle();
        end_test("irq");

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d ns", 2 * TEST_CYCLES * CLK_PERIOD);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
